// ==== ssc.f ====
ssc_pkg.sv
ssc_in_stage.sv
ssc_luhn_check.sv
ssc_sort4.sv
ssc_sort8.sv
ssc_change_calc.sv
ssc.sv
ssc_tb.sv

// ==== ssc_tb.sv ====
// ======================================================================
// Snack calculator testbench
// directed tests and a random stream
// every result is compared with a reference model two edges after
// its inputs
// ======================================================================

module ssc_tb
    import ssc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STREAM_LEN = 200;
    // reset, six single runs of two cycles each and the stream with its drain
    localparam int TEST_CYCLES = 4 + 2 * 6 + STREAM_LEN + 2;
    // twice the cycles that all tests take
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;
    // Luhn digit sum of this number is 80
    localparam card_t VALID_CARD = 64'h4539_1488_0343_6467;

    logic   clk;
    logic   rst;
    card_t  card_num;
    money_t input_money;
    items_t snack_num;
    items_t price;
    logic   out_valid;
    money_t out_change;

    integer seed = 5555;
    int     errors = 0;
    int     cycles = 0;
    int     tests_pass = 0;
    int     tests_fail = 0;
    // expected results in flight with the oldest at the front
    logic   exp_valid_q  [$];
    money_t exp_change_q [$];

    ssc ssc_i (
        .clk         (clk),
        .rst         (rst),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .out_valid   (out_valid),
        .out_change  (out_change)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("the run timed out after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ==================================================================
    // reference model
    // ==================================================================

    // odd digits from the check digit are doubled and lose nine above nine
    function automatic logic luhn_ok(input card_t c);
        int sum;
        int d;
        sum = 0;
        for (int i = 0; i < CARD_DIGITS; i++) begin
            d = int'(c[i*DIGIT_W +: DIGIT_W]);
            if (i % 2 == 1) begin
                d = (2 * d > 9) ? 2 * d - 9 : 2 * d;
            end
            sum = sum + d;
        end
        return (sum % 10) == 0;
    endfunction

    // buys the dearest item first and stops at the first cost that does not fit
    function automatic money_t model_change(input card_t c, input money_t m,
                                            input items_t s, input items_t p);
        int cost [NUM_ITEMS];
        int tmp;
        int left;
        for (int i = 0; i < NUM_ITEMS; i++) begin
            cost[i] = int'(s[i*DIGIT_W +: DIGIT_W]) * int'(p[i*DIGIT_W +: DIGIT_W]);
        end
        // plain descending bubble sort
        for (int i = 0; i < NUM_ITEMS; i++) begin
            for (int j = 0; j < NUM_ITEMS - 1 - i; j++) begin
                if (cost[j] < cost[j+1]) begin
                    tmp       = cost[j];
                    cost[j]   = cost[j+1];
                    cost[j+1] = tmp;
                end
            end
        end
        left = int'(m);
        for (int k = 0; k < NUM_ITEMS; k++) begin
            if (cost[k] > left) begin
                break;
            end
            left = left - cost[k];
        end
        return luhn_ok(c) ? money_t'(left) : m;
    endfunction

    // ==================================================================
    // compare, drive and report helpers
    // ==================================================================

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: out_valid expected %h, got %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_change(input money_t exp, input money_t act);
        if (act !== exp) begin
            $display("Error: out_change expected %h, got %h", exp, act);
            errors++;
        end
    endtask

    // drives at a falling edge and queues the expected result
    task automatic drive(input card_t c, input money_t m, input items_t s, input items_t p);
        card_num    = c;
        input_money = m;
        snack_num   = s;
        price       = p;
        exp_valid_q.push_back(luhn_ok(c));
        exp_change_q.push_back(model_change(c, m, s, p));
    endtask

    task automatic check_oldest();
        if (exp_valid_q.size() == 0) begin
            $display("a result was checked with no input set left in flight");
            errors++;
        end else begin
            check_valid(exp_valid_q.pop_front(), out_valid);
            check_change(exp_change_q.pop_front(), out_change);
        end
    endtask

    // result is stable at the second falling edge after driving
    task automatic run_one(input card_t c, input money_t m, input items_t s, input items_t p);
        drive(c, m, s, p);
        repeat (2) @(negedge clk);
        check_oldest();
    endtask

    // random digits 0..9 with a matching check digit about half the time
    task automatic drive_random();
        card_t c;
        for (int i = 0; i < CARD_DIGITS; i++) begin
            c[i*DIGIT_W +: DIGIT_W] = digit_t'($unsigned($random(seed)) % 10);
        end
        if ($random(seed) & 1) begin
            for (int d = 0; d < 10; d++) begin
                c[DIGIT_W-1:0] = digit_t'(d);
                if (luhn_ok(c)) begin
                    break;
                end
            end
        end
        drive(c, money_t'($random(seed)), items_t'($random(seed)),
              items_t'($random(seed)));
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_pass++;
            $display("%s: pass", name);
        end else begin
            tests_fail++;
            $display("%s: fail", name);
        end
    endtask

    // ==================================================================
    // tests
    // ==================================================================

    // inputs stay busy while the outputs stay cleared
    task automatic test_reset();
        int errs;
        errs = errors;
        rst = 1'b1;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_valid(1'b0, out_valid);
            check_change('0, out_change);
        end
        rst = 1'b0;
        report_test("reset", errs);
    endtask

    task automatic test_valid_all();
        int errs;
        errs = errors;
        // costs 1..8 for a total of 36
        run_one(VALID_CARD, 9'd300, 32'h1111_1111, 32'h1234_5678);
        report_test("valid card, all affordable", errs);
    endtask

    task automatic test_invalid_card();
        int errs;
        errs = errors;
        // check digit 7 turned into 6
        run_one(VALID_CARD ^ 64'h1, 9'd77, 32'h1111_1111, 32'h1234_5678);
        report_test("invalid card", errs);
    endtask

    task automatic test_partial();
        int errs;
        errs = errors;
        // costs 10 0 100 0 90 0 80 0 against 200
        // 80 overdraws while 10 would still fit
        run_one(VALID_CARD, 9'd200, 32'h10a0_9080, 32'ha0a0_a0a0);
        report_test("partial purchase", errs);
    endtask

    task automatic test_ties_zeros();
        int errs;
        errs = errors;
        // six equal costs of 6 and two zero slots
        run_one(VALID_CARD, 9'd40, 32'h2222_3300, 32'h3333_2200);
        // no counts at all
        run_one(VALID_CARD, 9'd123, 32'h0000_0000, 32'hffff_ffff);
        // 225 alone is above the money
        run_one(VALID_CARD, 9'd50, 32'hf000_0001, 32'hf000_0002);
        report_test("ties and zeros", errs);
    endtask

    // one set per cycle with two in flight
    task automatic test_stream();
        int errs;
        errs = errors;
        for (int n = 0; n < STREAM_LEN + 2; n++) begin
            if (n >= 2) begin
                check_oldest();
            end
            if (n < STREAM_LEN) begin
                drive_random();
            end
            @(negedge clk);
        end
        report_test("random stream", errs);
    endtask

    initial begin
        rst         = 1'b1;
        card_num    = VALID_CARD;
        input_money = 9'h1ff;
        snack_num   = 32'h1234_5678;
        price       = 32'h8765_4321;
        test_reset();
        test_valid_all();
        test_invalid_card();
        test_partial();
        test_ties_zeros();
        test_stream();
        $display("tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
        if (tests_fail == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== ssc.sv ====
// ======================================================================
// Snack shopping calculator, top level
// two stage pipeline: input register and item costs, then card check,
// cost sort and change into the output register
// ======================================================================

module ssc
    import ssc_pkg::*;
#(
    parameter int NUM_ITEMS   = ssc_pkg::NUM_ITEMS,
    parameter int CARD_DIGITS = ssc_pkg::CARD_DIGITS
) (
    input  logic   clk,
    input  logic   rst,
    input  card_t  card_num,
    input  money_t input_money,
    input  items_t snack_num,
    input  items_t price,
    output logic   out_valid,
    output money_t out_change
);

    // registered stage one outputs
    digit_t card_digit [CARD_DIGITS];
    money_t money;
    cost_t  cost [NUM_ITEMS];

    // stage two internals
    cost_t  sorted_cost [NUM_ITEMS];
    logic   card_ok;

    ssc_in_stage #(
        .NUM_ITEMS (NUM_ITEMS)
    ) in_stage_i (
        .clk         (clk),
        .rst         (rst),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .card_digit  (card_digit),
        .money       (money),
        .cost        (cost)
    );

    ssc_luhn_check #(
        .CARD_DIGITS (CARD_DIGITS)
    ) luhn_i (
        .card_digit (card_digit),
        .card_ok    (card_ok)
    );

    // largest cost first
    ssc_sort8 sort8_i (
        .in_val  (cost),
        .out_val (sorted_cost)
    );

    ssc_change_calc #(
        .NUM_ITEMS (NUM_ITEMS)
    ) change_i (
        .clk         (clk),
        .rst         (rst),
        .money       (money),
        .sorted_cost (sorted_cost),
        .card_ok     (card_ok),
        .out_valid   (out_valid),
        .out_change  (out_change)
    );

endmodule

// ==== ssc_change_calc.sv ====
// ======================================================================
// Snack calculator change stage
// spends the sorted costs in order, stops at the first overdraw
// and registers the card flag and the change
// ======================================================================

module ssc_change_calc
    import ssc_pkg::*;
#(
    parameter int NUM_ITEMS = ssc_pkg::NUM_ITEMS
) (
    input  logic   clk,
    input  logic   rst,
    input  money_t money,
    input  cost_t  sorted_cost [NUM_ITEMS],
    input  logic   card_ok,
    output logic   out_valid,
    output money_t out_change
);

    // one extra bit for the sign
    logic signed [MONEY_W:0] res [NUM_ITEMS];
    // sticky, set from the first negative step on
    logic                    overdraw [NUM_ITEMS];
    money_t                  change;

    // ==================================================================
    // subtraction chain
    // ==================================================================

    // first negative step starts from a non-negative value, no wrap
    always_comb begin
        for (int k = 0; k < NUM_ITEMS; k++) begin
            if (k == 0) begin
                res[k] = $signed((MONEY_W+1)'(money)) -
                         $signed((MONEY_W+1)'(sorted_cost[k]));
                overdraw[k] = res[k][MONEY_W];
            end else begin
                res[k] = res[k-1] - $signed((MONEY_W+1)'(sorted_cost[k]));
                overdraw[k] = res[k][MONEY_W] | overdraw[k-1];
            end
        end
    end

    // last step before the flag, or the full money if item 0 overdraws
    always_comb begin
        change = money;
        for (int k = 0; k < NUM_ITEMS; k++) begin
            if (!overdraw[k]) begin
                change = money_t'(res[k]);
            end
        end
    end

    // ==================================================================
    // output register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_change <= '0;
        end else begin
            out_valid <= card_ok;
            // bad card buys nothing
            out_change <= card_ok ? change : money;
        end
    end

endmodule

// ==== ssc_sort8.sv ====
// ======================================================================
// Eight entry descending sorter
// sorts both halves with four entry sorters, compares them rank by
// rank for the extremes and ranks the six middle candidates
// ======================================================================

module ssc_sort8
    import ssc_pkg::*;
(
    input  cost_t in_val  [8],
    output cost_t out_val [8]
);

    cost_t half_a   [4];
    cost_t half_b   [4];
    cost_t sorted_a [4];
    cost_t sorted_b [4];

    // per rank winner and loser of the two halves
    cost_t hi [4];
    cost_t lo [4];

    // everything except the overall max and min
    cost_t      cand      [6];
    logic [2:0] cand_rank [6];

    // split into items 0..3 and 4..7
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            half_a[i] = in_val[i];
            half_b[i] = in_val[i+4];
        end
    end

    ssc_sort4 sort_a_i (
        .in_val  (half_a),
        .out_val (sorted_a)
    );

    ssc_sort4 sort_b_i (
        .in_val  (half_b),
        .out_val (sorted_b)
    );

    // ==================================================================
    // merge
    // ==================================================================

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            hi[k] = (sorted_a[k] > sorted_b[k]) ? sorted_a[k] : sorted_b[k];
            lo[k] = (sorted_a[k] > sorted_b[k]) ? sorted_b[k] : sorted_a[k];
        end
        // hi[0] is the max, lo[3] the min
        cand[0] = lo[0];
        cand[1] = hi[1];
        cand[2] = lo[1];
        cand[3] = hi[2];
        cand[4] = lo[2];
        cand[5] = hi[3];
        // ranks among the middle six, ties to lower index
        for (int i = 0; i < 6; i++) begin
            cand_rank[i] = '0;
            for (int j = 0; j < 6; j++) begin
                if ((j != i) && ((cand[j] > cand[i]) || ((cand[j] == cand[i]) && (j < i)))) begin
                    cand_rank[i] = cand_rank[i] + 3'd1;
                end
            end
        end
        out_val[0] = hi[0];
        out_val[7] = lo[3];
        // one hot and-or select per middle rank
        for (int r = 0; r < 6; r++) begin
            out_val[r+1] = '0;
            for (int i = 0; i < 6; i++) begin
                if (cand_rank[i] == 3'(r)) begin
                    out_val[r+1] = out_val[r+1] | cand[i];
                end
            end
        end
    end

endmodule

// ==== ssc_sort4.sv ====
// ======================================================================
// Four entry descending sorter
// each input gets a rank from pairwise compares, then every output
// rank picks its input through its own parallel select
// ======================================================================

module ssc_sort4
    import ssc_pkg::*;
(
    input  cost_t in_val  [4],
    output cost_t out_val [4]
);

    // final position of each input, 0 is the largest
    logic [1:0] rank [4];

    // ==================================================================
    // ranking
    // ==================================================================

    // count the inputs that must go ahead of input i
    // on a tie the lower index goes first
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rank[i] = '0;
            for (int j = 0; j < 4; j++) begin
                if (j != i) begin
                    if ((in_val[j] > in_val[i]) || ((in_val[j] == in_val[i]) && (j < i))) begin
                        rank[i] = rank[i] + 2'd1;
                    end
                end
            end
        end
    end

    // ==================================================================
    // rank selects
    // ==================================================================

    // ranks form a permutation, so the arms never overlap
    for (genvar r = 0; r < 4; r++) begin : g_rank
        always_comb begin
            unique case (1'b1)
                (rank[0] == 2'(r)): out_val[r] = in_val[0];
                (rank[1] == 2'(r)): out_val[r] = in_val[1];
                (rank[2] == 2'(r)): out_val[r] = in_val[2];
                default:            out_val[r] = in_val[3];
            endcase
        end
    end

endmodule

// ==== ssc_luhn_check.sv ====
// ======================================================================
// Luhn (mod 10) card check
// doubles every second digit, folds values above nine and flags a
// digit sum that is a multiple of the modulus
// ======================================================================

module ssc_luhn_check
    import ssc_pkg::*;
#(
    parameter int CARD_DIGITS = ssc_pkg::CARD_DIGITS
) (
    input  digit_t card_digit [CARD_DIGITS],
    output logic   card_ok
);

    // worst case every digit contributes nine
    localparam int SUM_W = $clog2(CARD_DIGITS * (LUHN_MOD - 1) + 1);

    // digit after doubling and fold
    digit_t           folded [CARD_DIGITS];
    logic [SUM_W-1:0] digit_sum;

    // ==================================================================
    // doubling with the minus nine correction
    // ==================================================================

    always_comb begin
        logic [DIGIT_W:0] dbl;
        dbl = '0;
        for (int i = 0; i < CARD_DIGITS; i++) begin
            if (i % 2 == 1) begin
                // odd positions, counted from the check digit
                dbl = {card_digit[i], 1'b0};
                if (dbl > (DIGIT_W+1)'(LUHN_MOD - 1)) begin
                    folded[i] = digit_t'(dbl - (DIGIT_W+1)'(LUHN_MOD - 1));
                end else begin
                    folded[i] = digit_t'(dbl);
                end
            end else begin
                folded[i] = card_digit[i];
            end
        end
    end

    // ==================================================================
    // digit sum and modulus test
    // ==================================================================

    always_comb begin
        digit_sum = '0;
        for (int i = 0; i < CARD_DIGITS; i++) begin
            digit_sum = digit_sum + SUM_W'(folded[i]);
        end
    end

    // valid when the sum ends in zero
    assign card_ok = ((digit_sum % LUHN_MOD) == 0);

endmodule

// ==== ssc_in_stage.sv ====
// ======================================================================
// Snack calculator input stage
// registers the card digits and the money, and forms each item cost
// (count times price) ahead of its register
// ======================================================================

module ssc_in_stage
    import ssc_pkg::*;
#(
    parameter int NUM_ITEMS = ssc_pkg::NUM_ITEMS
) (
    input  logic   clk,
    input  logic   rst,
    input  card_t  card_num,
    input  money_t input_money,
    input  items_t snack_num,
    input  items_t price,
    output digit_t card_digit [CARD_DIGITS],
    output money_t money,
    output cost_t  cost [NUM_ITEMS]
);

    // per item product, before the register
    cost_t cost_d [NUM_ITEMS];

    // item 0 comes from the top nibble
    always_comb begin
        for (int i = 0; i < NUM_ITEMS; i++) begin
            cost_d[i] = cost_t'(snack_num[(NUM_ITEMS-1-i)*DIGIT_W +: DIGIT_W]) *
                        cost_t'(price[(NUM_ITEMS-1-i)*DIGIT_W +: DIGIT_W]);
        end
    end

    // ==================================================================
    // input register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            money <= '0;
            for (int d = 0; d < CARD_DIGITS; d++) begin
                card_digit[d] <= '0;
            end
            for (int i = 0; i < NUM_ITEMS; i++) begin
                cost[i] <= '0;
            end
        end else begin
            money <= input_money;
            // unpack card, digit 0 from the low nibble
            for (int d = 0; d < CARD_DIGITS; d++) begin
                card_digit[d] <= card_num[d*DIGIT_W +: DIGIT_W];
            end
            for (int i = 0; i < NUM_ITEMS; i++) begin
                cost[i] <= cost_d[i];
            end
        end
    end

endmodule

// ==== ssc_pkg.sv ====
// ======================================================================
// Snack shopping calculator shared definitions
// widths, slot counts and the payload types used by every stage
// ======================================================================

package ssc_pkg;

    // ==================================================================
    // sizes
    // ==================================================================

    // snack slots per purchase
    parameter int NUM_ITEMS   = 8;
    // card number length in BCD digits
    parameter int CARD_DIGITS = 16;

    // one BCD digit, also one count or one price
    parameter int DIGIT_W = 4;
    // money in and change out
    parameter int MONEY_W = 9;
    // count times price, two digits wide
    parameter int COST_W  = 8;

    // Luhn check modulus
    parameter int LUHN_MOD = 10;

    // ==================================================================
    // types
    // ==================================================================

    typedef logic [DIGIT_W-1:0] digit_t;
    typedef logic [COST_W-1:0]  cost_t;
    typedef logic [MONEY_W-1:0] money_t;

    // digit 0 sits in the lowest nibble
    typedef logic [CARD_DIGITS*DIGIT_W-1:0] card_t;

    // item 0 sits in the highest nibble
    typedef logic [NUM_ITEMS*DIGIT_W-1:0] items_t;

endpackage
